/* design/fb_pkg.sv */
/*
 * shared widths, AXI register map and response codes
 * state and grant enums for the framebuffer blocks
 */
package fb_pkg;

    localparam int CIDXW     = 4;           // colour index bits, 16 entries
    localparam int CHANW     = 4;           // bits per channel
    localparam int PALW      = 3 * CHANW;   // rgb entry, red on top
    localparam int CORDW     = 8;           // signed draw coordinate
    localparam int CLIPW     = 16;          // clipped-draw counter
    localparam int AXI_ADDRW = 8;           // byte address
    localparam int AXI_DATAW = 32;

    // register map
    localparam logic [AXI_ADDRW-1:0] REG_DRAW    = 8'h00;  // x, y, cidx
    localparam logic [AXI_ADDRW-1:0] REG_STATUS  = 8'h04;  // clip count, busy
    localparam logic [AXI_ADDRW-1:0] REG_PALETTE = 8'h40;  // 16 words

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        W_IDLE,       // waiting for aw and w together
        W_DRAW_WAIT,  // draw offered to pixel writer
        W_RESP,       // bvalid up
        R_IDLE,
        R_DATA        // rvalid up
    } axi_state_e;

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_FETCH,
        GRANT_DRAW
    } grant_e;

    typedef enum logic [1:0] {
        F_IDLE,
        F_READ,   // one read per cycle
        F_DRAIN   // waiting out memory and palette latency
    } fetch_state_e;

endpackage

/* design/fb_bram.sv */
/*
 * single-port framebuffer memory, registered read
 */
`timescale 1ns/1ns

module fb_bram #(
    parameter int DEPTH = 32,
    parameter int DATAW = 4
) (
    input  logic                     clk_sys,
    input  logic                     en,      // port enable
    input  logic                     we,      // write when enabled
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [DATAW-1:0]         din,
    output logic [DATAW-1:0]         dout     // one cycle after read
);

    logic [DATAW-1:0] mem [DEPTH];  // no init, contents undefined

    always_ff @(posedge clk_sys) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;  // dout keeps last read
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

/* design/fb_arbiter.sv */
/*
 * memory port arbiter, line fetcher ahead of pixel writer
 */
`timescale 1ns/1ns

module fb_arbiter
    import fb_pkg::*;
#(
    parameter int ADDRW = 5
) (
    input  logic             rd_req,    // line fetcher
    input  logic [ADDRW-1:0] rd_addr,
    output logic             rd_gnt,
    input  logic             wr_req,    // pixel writer
    input  logic [ADDRW-1:0] wr_addr,
    input  logic [CIDXW-1:0] wr_data,
    output logic             wr_gnt,
    output logic             mem_en,    // to fb_bram
    output logic             mem_we,
    output logic [ADDRW-1:0] mem_addr,
    output logic [CIDXW-1:0] mem_din
);

    grant_e grant;

    // fetcher always first, writer waits at most one line
    always_comb begin
        if (rd_req) begin
            grant = GRANT_FETCH;
        end else if (wr_req) begin
            grant = GRANT_DRAW;
        end else begin
            grant = GRANT_NONE;
        end
    end

    assign rd_gnt = (grant == GRANT_FETCH);
    assign wr_gnt = (grant == GRANT_DRAW);

    // memory port follows the winner
    assign mem_en   = (grant != GRANT_NONE);
    assign mem_we   = (grant == GRANT_DRAW);
    assign mem_addr = (grant == GRANT_DRAW) ? wr_addr : rd_addr;
    assign mem_din  = wr_data;  // only written on draw grant

endmodule

/* design/pixel_writer.sv */
/*
 * draw pipeline, coordinates to address in two stages
 * clipped pixels are dropped, others held until granted
 */
`timescale 1ns/1ns

module pixel_writer
    import fb_pkg::*;
#(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 4
) (
    input  logic                            clk_sys,
    input  logic                            rst_sys,
    input  logic                            draw_valid,
    input  logic signed [CORDW-1:0]         draw_x,
    input  logic signed [CORDW-1:0]         draw_y,
    input  logic [CIDXW-1:0]                draw_cidx,
    output logic                            draw_ready,
    output logic                            clip,       // one pulse per clipped draw
    output logic                            wr_req,
    output logic [$clog2(WIDTH*HEIGHT)-1:0] wr_addr,
    output logic [CIDXW-1:0]                wr_data,
    input  logic                            wr_gnt
);

    localparam int ADDRW = $clog2(WIDTH * HEIGHT);

    logic                    s1_valid;
    logic                    s1_clip;   // out of bounds
    logic [ADDRW-1:0]        s1_line;   // y * WIDTH
    logic signed [CORDW-1:0] s1_x;
    logic [CIDXW-1:0]        s1_cidx;
    logic                    draw_take;

    // one pixel in flight at a time
    assign draw_ready = !s1_valid && !wr_req;
    assign draw_take  = draw_valid && draw_ready;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            s1_valid <= 1'b0;
            clip     <= 1'b0;
            wr_req   <= 1'b0;
        end else begin
            s1_valid <= draw_take;
            clip     <= s1_valid && s1_clip;  // stage 2 pulse
            if (s1_valid && !s1_clip) begin
                wr_req <= 1'b1;
            end else if (wr_gnt) begin
                wr_req <= 1'b0;  // written this cycle
            end
        end
    end

    // stage 1 multiply and bounds, stage 2 add
    always_ff @(posedge clk_sys) begin
        if (draw_take) begin
            s1_line <= ADDRW'(draw_y * WIDTH);  // junk when clipped, unused
            s1_x    <= draw_x;
            s1_cidx <= draw_cidx;
            s1_clip <= (draw_x < 0) || (draw_x >= WIDTH) ||
                       (draw_y < 0) || (draw_y >= HEIGHT);
        end
        if (s1_valid) begin
            wr_addr <= s1_line + ADDRW'(s1_x);
            wr_data <= s1_cidx;
        end
    end

endmodule

/* design/line_fetch.sv */
/*
 * line fetcher, WIDTH reads from line_num * WIDTH
 * palette mapped and streamed as rgb, one pixel per cycle
 */
`timescale 1ns/1ns

module line_fetch
    import fb_pkg::*;
#(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 4
) (
    input  logic                            clk_sys,
    input  logic                            rst_sys,
    input  logic                            line_start,  // taken only when idle
    input  logic [$clog2(HEIGHT+1)-1:0]     line_num,
    output logic                            rd_req,
    output logic [$clog2(WIDTH*HEIGHT)-1:0] rd_addr,
    input  logic                            rd_gnt,
    input  logic [CIDXW-1:0]                mem_dout,
    output logic [CIDXW-1:0]                pal_idx,     // palette lookup
    input  logic [PALW-1:0]                 pal_rgb,
    output logic                            pix_valid,
    output logic [CHANW-1:0]                red,
    output logic [CHANW-1:0]                green,
    output logic [CHANW-1:0]                blue,
    output logic                            fetch_busy
);

    localparam int ADDRW = $clog2(WIDTH * HEIGHT);
    localparam int CNTW  = $clog2(WIDTH);

    fetch_state_e    state;
    logic [CNTW-1:0] cnt;     // reads granted so far
    logic [1:0]      rd_sr;   // read enable through memory and palette
    logic            oob;     // line beyond HEIGHT, blank pixels
    logic            start;

    assign start      = (state == F_IDLE) && line_start;
    assign rd_req     = (state == F_READ);
    assign fetch_busy = (state != F_IDLE);
    assign pal_idx    = mem_dout;  // memory data straight to palette
    assign pix_valid  = rd_sr[1];

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state <= F_IDLE;
            rd_sr <= 2'b00;
        end else begin
            rd_sr <= {rd_sr[0], rd_gnt};
            case (state)
                F_IDLE: begin
                    if (line_start) state <= F_READ;
                end
                F_READ: begin
                    if (rd_gnt && cnt == CNTW'(WIDTH - 1)) state <= F_DRAIN;
                end
                F_DRAIN: begin
                    if (!rd_sr[0]) state <= F_IDLE;  // last pixel on its way out
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // read address and count advance on grant only
    always_ff @(posedge clk_sys) begin
        if (start) begin
            rd_addr <= ADDRW'(line_num * WIDTH);
            cnt     <= '0;
            oob     <= (line_num >= HEIGHT);
        end else if (rd_gnt) begin
            rd_addr <= rd_addr + 1'b1;
            cnt     <= cnt + 1'b1;
        end
    end

    // palette register, zero outside the line
    always_ff @(posedge clk_sys) begin
        if (rd_sr[0] && !oob) begin
            {red, green, blue} <= pal_rgb;
        end else begin
            {red, green, blue} <= '0;
        end
    end

endmodule

/* design/fb_regs.sv */
/*
 * AXI4-Lite slave with palette, draw register and clip counter
 */
`timescale 1ns/1ns

module fb_regs
    import fb_pkg::*;
(
    input  logic                     clk_sys,
    input  logic                     rst_sys,
    input  logic [AXI_ADDRW-1:0]     awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [AXI_DATAW-1:0]     wdata,
    input  logic [AXI_DATAW/8-1:0]   wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [AXI_ADDRW-1:0]     araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [AXI_DATAW-1:0]     rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     draw_valid,
    output logic signed [CORDW-1:0]  draw_x,
    output logic signed [CORDW-1:0]  draw_y,
    output logic [CIDXW-1:0]         draw_cidx,
    input  logic                     draw_ready,
    input  logic                     clip,
    input  logic                     fetch_busy,
    input  logic [CIDXW-1:0]         pal_idx,
    output logic [PALW-1:0]          pal_rgb
);

    axi_state_e       wstate;
    axi_state_e       rstate;
    logic [PALW-1:0]  palette [2**CIDXW];
    logic [CLIPW-1:0] clip_cnt;
    logic             w_take;      // aw and w accepted together
    logic             aw_pal;
    logic             ar_pal;
    logic [CIDXW-1:0] aw_idx;      // palette word from address
    logic [CIDXW-1:0] ar_idx;

    assign awready = (wstate == W_IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign w_take  = awready;
    assign bvalid  = (wstate == W_RESP);
    assign draw_valid = (wstate == W_DRAW_WAIT);  // held until writer takes it
    assign arready = (rstate == R_IDLE) && arvalid;
    assign rvalid  = (rstate == R_DATA);

    // palette window 0x40..0x7f
    assign aw_pal = (awaddr[AXI_ADDRW-1:6] == REG_PALETTE[AXI_ADDRW-1:6]);
    assign ar_pal = (araddr[AXI_ADDRW-1:6] == REG_PALETTE[AXI_ADDRW-1:6]);
    assign aw_idx = awaddr[CIDXW+1:2];
    assign ar_idx = araddr[CIDXW+1:2];

    assign pal_rgb = palette[pal_idx];  // combinational lookup for fetcher

    // write path
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            wstate <= W_IDLE;
            bresp  <= RESP_OKAY;
            for (int i = 0; i < 2**CIDXW; i++) begin
                palette[i] <= '0;
            end
        end else begin
            case (wstate)
                W_IDLE: begin
                    if (w_take) begin
                        bresp <= RESP_OKAY;
                        if (awaddr == REG_DRAW) begin
                            wstate <= W_DRAW_WAIT;
                        end else if (aw_pal) begin
                            if (wstrb[0]) palette[aw_idx][7:0] <= wdata[7:0];
                            if (wstrb[1]) palette[aw_idx][PALW-1:8] <= wdata[PALW-1:8];
                            wstate <= W_RESP;
                        end else begin
                            bresp  <= RESP_SLVERR;  // status or unmapped
                            wstate <= W_RESP;
                        end
                    end
                end
                W_DRAW_WAIT: begin
                    if (draw_ready) wstate <= W_RESP;  // response waits on writer
                end
                W_RESP: begin
                    if (bready) wstate <= W_IDLE;
                end
                default: wstate <= W_IDLE;
            endcase
        end
    end

    // draw payload, latched at acceptance
    always_ff @(posedge clk_sys) begin
        if (w_take && awaddr == REG_DRAW) begin
            draw_x    <= wdata[7:0];
            draw_y    <= wdata[15:8];
            draw_cidx <= wdata[16+:CIDXW];
        end
    end

    // clip counter, saturating
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            clip_cnt <= '0;
        end else if (clip && clip_cnt != '1) begin
            clip_cnt <= clip_cnt + 1'b1;
        end
    end

    // read path
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            rstate <= R_IDLE;
            rresp  <= RESP_OKAY;
            rdata  <= '0;
        end else begin
            case (rstate)
                R_IDLE: begin
                    if (arvalid) begin
                        rstate <= R_DATA;
                        rresp  <= RESP_OKAY;
                        if (araddr == REG_STATUS) begin
                            rdata <= AXI_DATAW'({fetch_busy, clip_cnt});
                        end else if (ar_pal) begin
                            rdata <= AXI_DATAW'(palette[ar_idx]);
                        end else begin
                            rdata <= '0;
                            rresp <= RESP_SLVERR;  // draw reg is write only
                        end
                    end
                end
                R_DATA: begin
                    if (rready) rstate <= R_IDLE;
                end
                default: rstate <= R_IDLE;
            endcase
        end
    end

endmodule

/* design/framebuffer_top.sv */
/*
 * framebuffer top, register block, writer, fetcher, arbiter, memory
 */
`timescale 1ns/1ns

module framebuffer_top
    import fb_pkg::*;
#(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 4
) (
    input  logic                        clk_sys,
    input  logic                        rst_sys,
    input  logic [AXI_ADDRW-1:0]        awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [AXI_DATAW-1:0]        wdata,
    input  logic [AXI_DATAW/8-1:0]      wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [AXI_ADDRW-1:0]        araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [AXI_DATAW-1:0]        rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic                        line_start,  // display side
    input  logic [$clog2(HEIGHT+1)-1:0] line_num,
    output logic                        pix_valid,
    output logic [CHANW-1:0]            red,
    output logic [CHANW-1:0]            green,
    output logic [CHANW-1:0]            blue
);

    localparam int ADDRW = $clog2(WIDTH * HEIGHT);

    logic                    draw_valid, draw_ready, clip, fetch_busy;
    logic signed [CORDW-1:0] draw_x, draw_y;
    logic [CIDXW-1:0]        draw_cidx, pal_idx;
    logic [PALW-1:0]         pal_rgb;
    logic                    wr_req, wr_gnt, rd_req, rd_gnt;
    logic [ADDRW-1:0]        wr_addr, rd_addr, mem_addr;
    logic [CIDXW-1:0]        wr_data, mem_din, mem_dout;
    logic                    mem_en, mem_we;

    fb_regs regs0 (
        .clk_sys, .rst_sys,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .draw_valid, .draw_x, .draw_y, .draw_cidx, .draw_ready,
        .clip, .fetch_busy, .pal_idx, .pal_rgb
    );

    pixel_writer #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) writer0 (
        .clk_sys, .rst_sys,
        .draw_valid, .draw_x, .draw_y, .draw_cidx, .draw_ready,
        .clip, .wr_req, .wr_addr, .wr_data, .wr_gnt
    );

    line_fetch #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) fetch0 (
        .clk_sys, .rst_sys, .line_start, .line_num,
        .rd_req, .rd_addr, .rd_gnt, .mem_dout,
        .pal_idx, .pal_rgb,
        .pix_valid, .red, .green, .blue, .fetch_busy
    );

    fb_arbiter #(.ADDRW(ADDRW)) arb0 (
        .rd_req, .rd_addr, .rd_gnt,
        .wr_req, .wr_addr, .wr_data, .wr_gnt,
        .mem_en, .mem_we, .mem_addr, .mem_din
    );

    fb_bram #(.DEPTH(WIDTH * HEIGHT), .DATAW(CIDXW)) bram0 (
        .clk_sys,
        .en(mem_en), .we(mem_we), .addr(mem_addr), .din(mem_din), .dout(mem_dout)
    );

endmodule

/* bench/tb_framebuffer.sv */
/*
 * testbench for framebuffer_top, AXI4-Lite host tasks and line capture
 * runs the operations listed in bench/framebuffer_tests.txt
 */
`timescale 1ns/1ns

module tb_framebuffer
    import fb_pkg::*;
();

    localparam int WIDTH  = 8;
    localparam int HEIGHT = 4;
    localparam int LAT    = 3;                  // line_start to first pixel

    logic                        clk_sys;
    logic                        rst_sys;
    logic [AXI_ADDRW-1:0]        awaddr;
    logic                        awvalid, awready;
    logic [AXI_DATAW-1:0]        wdata;
    logic [AXI_DATAW/8-1:0]      wstrb;
    logic                        wvalid, wready;
    logic [1:0]                  bresp;
    logic                        bvalid, bready;
    logic [AXI_ADDRW-1:0]        araddr;
    logic                        arvalid, arready;
    logic [AXI_DATAW-1:0]        rdata;
    logic [1:0]                  rresp;
    logic                        rvalid, rready;
    logic                        line_start;
    logic [$clog2(HEIGHT+1)-1:0] line_num;
    logic                        pix_valid;
    logic [CHANW-1:0]            red, green, blue;

    string       ops [$];                       // op lines from the data file
    string       line;
    string       op;
    string       name;                          // current test
    logic [31:0] fld [11];                      // hex fields after the name
    logic [1:0]  wr_resp;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;
    logic [11:0] got_pix [WIDTH];               // captured rgb
    int          got_cnt;
    int          got_first;                     // cycle of first pix_valid
    int          got_last;
    int          fd;
    int          nread;
    int          idx;
    int          done;
    int          cycles;
    int          cycle_limit;
    int          test_err;
    int          pass_cnt;
    int          fail_cnt;

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;          // 8 ns period
    end

    framebuffer_top #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) dut0 (
        .clk_sys, .rst_sys,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .line_start, .line_num, .pix_valid, .red, .green, .blue
    );

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s (%s) expected 0x%0h actual 0x%0h", name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic axi_write(input logic [AXI_ADDRW-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int dly;
        dly = $urandom % 3;                     // bready delay
        @(posedge clk_sys);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        @(negedge clk_sys);
        while (!awready) @(negedge clk_sys);    // stalled while writer busy
        compare_value("wready with awready", 1'b1, wready);  // aw and w taken together
        @(posedge clk_sys);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (dly) @(posedge clk_sys);
        bready <= 1'b1;
        @(negedge clk_sys);
        while (!bvalid) @(negedge clk_sys);
        resp = bresp;
        @(posedge clk_sys);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDRW-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int dly;
        dly = $urandom % 3;                     // rready delay
        @(posedge clk_sys);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk_sys);
        while (!arready) @(negedge clk_sys);
        @(posedge clk_sys);
        arvalid <= 1'b0;
        repeat (dly) @(posedge clk_sys);
        rready <= 1'b1;
        @(negedge clk_sys);
        while (!rvalid) @(negedge clk_sys);
        data = rdata;
        resp = rresp;
        @(posedge clk_sys);
        rready <= 1'b0;
    endtask

    // 16 cycle capture window from line_start
    task automatic fetch_line(input logic [$clog2(HEIGHT+1)-1:0] num);
        int cyc;
        cyc       = 0;
        got_cnt   = 0;
        got_first = -1;
        got_last  = -1;
        @(posedge clk_sys);
        line_start <= 1'b1;
        line_num   <= num;
        while (cyc < 16) begin
            @(posedge clk_sys);
            cyc++;
            line_start <= (cyc == 2);           // repeat start while busy
            @(negedge clk_sys);
            if (pix_valid) begin
                if (got_cnt == 0) got_first = cyc;
                if (got_cnt < WIDTH) got_pix[got_cnt] = {red, green, blue};
                got_cnt++;
                got_last = cyc;
            end
        end
    endtask

    task automatic compare_line(input int base);
        compare_value("first pixel cycle", LAT, got_first);
        compare_value("pixel count", WIDTH, got_cnt);
        compare_value("last pixel cycle", LAT + WIDTH - 1, got_last);
        for (int i = 0; i < WIDTH; i++) begin
            compare_value($sformatf("pixel %0d", i), fld[base+i], {20'h0, got_pix[i]});
        end
    endtask

    task automatic clear_frame();
        logic [1:0] resp;
        for (int y = 0; y < HEIGHT; y++) begin
            for (int x = 0; x < WIDTH; x++) begin
                axi_write(REG_DRAW, {16'h0, 8'(y), 8'(x)}, 4'hf, resp);  // index 0
                compare_value("clear response", RESP_OKAY, resp);
            end
        end
    endtask

    task automatic run_op();
        if (op == "W") begin
            axi_write(fld[0][7:0], fld[1], fld[2][3:0], wr_resp);
            compare_value("write response", fld[3], wr_resp);
        end else if (op == "R") begin
            axi_read(fld[0][7:0], rd_data, rd_resp);
            compare_value("read data", fld[1], rd_data);
            compare_value("read response", fld[2], rd_resp);
        end else if (op == "L") begin
            fetch_line(fld[0][2:0]);
            compare_line(1);
        end else if (op == "P") begin
            fork                                // draw lands on the line_start edge
                axi_write(REG_DRAW, fld[1], 4'hf, wr_resp);
                fetch_line(fld[0][2:0]);
            join
            compare_value("draw response", fld[2], wr_resp);
            compare_line(3);
        end else if (op == "C") begin
            clear_frame();
        end else begin
            $display("unknown operation %s in test %s", op, name);
            test_err++;
        end
    endtask

    always @(posedge clk_sys) cycles <= cycles + 1;

    initial begin
        wait (cycle_limit > 0);
        wait (cycles >= cycle_limit);
        $display("timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_sys    <= 1'b1;
        awaddr     <= '0;
        awvalid    <= 1'b0;
        wdata      <= '0;
        wstrb      <= '0;
        wvalid     <= 1'b0;
        bready     <= 1'b0;
        araddr     <= '0;
        arvalid    <= 1'b0;
        rready     <= 1'b0;
        line_start <= 1'b0;
        line_num   <= '0;
        cycle_limit = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        done        = 0;
        void'($urandom(68));                    // one seed for the whole run
        fd = $fopen("bench/framebuffer_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open test file bench/framebuffer_tests.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line  = "";
                nread = $fgets(line, fd);
                if (nread > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    ops.push_back(line);        // skip comments and blanks
                end
            end
            $fclose(fd);
        end
        cycle_limit = 200 * ops.size();
        repeat (4) @(posedge clk_sys);
        rst_sys <= 1'b0;
        idx = 0;
        while (idx < ops.size() && !done) begin
            for (int k = 0; k < 11; k++) begin
                fld[k] = '0;
            end
            op    = "";
            name  = "";
            nread = $sscanf(ops[idx], "%s %s %h %h %h %h %h %h %h %h %h %h %h",
                            op, name, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                            fld[6], fld[7], fld[8], fld[9], fld[10]);
            if (op == "E") begin
                done = 1;
            end else begin
                test_err = 0;
                run_op();
                if (test_err == 0) begin
                    pass_cnt++;
                    $display("%s: passed", name);
                end else begin
                    fail_cnt++;
                    $display("%s: failed with %0d errors", name, test_err);
                end
            end
            idx++;
        end
        if (!done && ops.size() > 0) begin
            $display("test file ended without an end line");
            fail_cnt++;
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/framebuffer_tests.txt */
# op name then hex fields: W addr data strb resp | R addr data resp | C draws index 0 everywhere
# L line c0..c7 | P line draw_data resp c0..c7, draw issued with line_start | E ends the list
W pal0_wr 40 ffff0123 f 0
R pal0_rd 40 00000123 0
W pal1_wr 44 fffffabc f 0
W pal1_strb 44 00000d55 2 0
R pal1_rd 44 00000dbc 0
W pal2_wr 48 00000f00 f 0
R unmapped_rd 20 00000000 2
W status_wr 04 00000001 f 2
C clear_all
W draw_1_0 00 00010001 f 0
W draw_3_0 00 00020003 f 0
W draw_7_0 00 00030007 f 0
W draw_0_2 00 00020200 f 0
W clip_neg_x 00 000100ff f 0
W clip_big_x 00 00010008 f 0
W clip_big_y 00 00010400 f 0
W clip_neg_y 00 0001ff00 f 0
R clip_count 04 00000004 0
L line0 0 123 dbc 123 f00 123 123 123 000
L line1 1 123 123 123 123 123 123 123 123
L line2 2 f00 123 123 123 123 123 123 123
L line3 3 123 123 123 123 123 123 123 123
L line4_blank 4 000 000 000 000 000 000 000 000
W pal2_change 48 00000070 f 0
L line0_repal 0 123 dbc 123 070 123 123 123 000
P draw_in_fetch 2 00030205 0 070 123 123 123 123 123 123 123
L line2_after 2 070 123 123 123 123 000 123 123
E end

/* compile.f */
design/fb_pkg.sv
design/fb_bram.sv
design/fb_arbiter.sv
design/pixel_writer.sv
design/line_fetch.sv
design/fb_regs.sv
design/framebuffer_top.sv
bench/tb_framebuffer.sv
